//--- Makefile
# Verilator build for the execute coprocessor

VERILATOR := verilator
TB_TOP    := tb_exec_top
RTL_TOP   := exec_top
FILELIST  := build.f
FLAGS     := --timing --assert --timescale 1ns/1ps
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# The run counts as passed only when the log holds the pass line
sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- alu_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module alu_shifter (
    input  wire exec_pkg::word_t      a,
    input  wire exec_pkg::word_t      b,
    input  wire exec_pkg::exec_op_e   op,
    output exec_pkg::word_t           result,
    output exec_pkg::alu_flags_t      flags
);
    import exec_pkg::*;

    word_t  sum;
    word_t  diff;
    word_t  alu_out;
    word_t  shift_out;
    shamt_t shamt;
    logic   add_ovf;
    logic   sub_ovf;
    logic   signed_lt;
    logic   is_alu;
    logic   is_shift;

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    assign sum       = a + b;
    assign diff      = a - b;
    // Signed overflow from the operand and result signs
    assign add_ovf   = (a[31] == b[31]) && (sum[31] != a[31]);
    assign sub_ovf   = (a[31] != b[31]) && (diff[31] != a[31]);
    assign signed_lt = $signed(a) < $signed(b);

    always_comb begin
        is_alu = 1'b1;
        case (op)
            OP_ADD:  alu_out = sum;
            OP_SUB:  alu_out = diff;
            OP_AND:  alu_out = a & b;
            OP_OR:   alu_out = a | b;
            OP_XOR:  alu_out = a ^ b;
            OP_NOR:  alu_out = ~(a | b);
            OP_SLT:  alu_out = word_t'(signed_lt);
            OP_SLTU: alu_out = word_t'(a < b);
            default: begin
                alu_out = '0;
                is_alu  = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Barrel shifter
    ////////////////////////////////////////////////////////////

    // Variable shifts only, amount from operand A
    assign shamt = a[4:0];

    always_comb begin
        is_shift = 1'b1;
        case (op)
            OP_SLL:  shift_out = b << shamt;
            OP_SRL:  shift_out = b >> shamt;
            OP_SRA:  shift_out = word_t'($signed(b) >>> shamt);
            default: begin
                shift_out = '0;
                is_shift  = 1'b0;
            end
        endcase
    end

    // Result select and flags, mul/div opcodes give zero and no flags
    always_comb begin
        if (is_shift) begin
            result = shift_out;
        end else if (is_alu) begin
            result = alu_out;
        end else begin
            result = '0;
        end
        flags.zero     = (is_alu || is_shift) && (result == '0);
        flags.less     = is_alu && signed_lt;
        flags.overflow = ((op == OP_ADD) && add_ovf) || ((op == OP_SUB) && sub_ovf);

        if (!$isunknown(op) && !$isunknown(a) && !$isunknown(b)) begin
            assert (!$isunknown(flags))
                else $error("ALU flags unknown for op %0d", op);
        end
    end

endmodule

`default_nettype wire

//--- apb_pkg.sv
`default_nettype none

package apb_pkg;

    // Byte address within the coprocessor window
    typedef logic [7:0] apb_addr_t;

    // Master to slave
    typedef struct packed {
        logic            psel;
        logic            penable;
        logic            pwrite;
        apb_addr_t       paddr;
        exec_pkg::word_t pwdata;
    } apb_req_t;

    // Slave to master
    typedef struct packed {
        exec_pkg::word_t prdata;
        logic            pready;
        logic            pslverr;
    } apb_rsp_t;

    ////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////

    // Operands, read/write
    localparam apb_addr_t REG_OP_A   = 8'h00;
    localparam apb_addr_t REG_OP_B   = 8'h04;
    // Command, write only
    localparam apb_addr_t REG_CMD    = 8'h08;
    // Results and flags, read only
    localparam apb_addr_t REG_RESULT = 8'h0C;
    localparam apb_addr_t REG_HI     = 8'h10;
    localparam apb_addr_t REG_LO     = 8'h14;
    localparam apb_addr_t REG_STATUS = 8'h18;

endpackage

`default_nettype wire

//--- build.f
exec_pkg.sv
apb_pkg.sv
alu_shifter.sv
md_sequencer.sv
md_step_counter.sv
muldiv_datapath.sv
exec_regs.sv
exec_top.sv
tb_exec_top.sv

//--- exec_pkg.sv
`default_nettype none

package exec_pkg;

    // Data and control widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [4:0]  md_count_t;

    // One product or quotient bit per step
    localparam int MD_STEPS = 32;

    // Command opcodes, written to the command register
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_NOR  = 4'd5,
        OP_SLT  = 4'd6,
        OP_SLTU = 4'd7,
        OP_SLL  = 4'd8,
        OP_SRL  = 4'd9,
        OP_SRA  = 4'd10,
        OP_MULU = 4'd11,
        OP_DIVU = 4'd12
    } exec_op_e;

    // Status bits, zero in bit 2 down to overflow in bit 0
    typedef struct packed {
        logic zero;
        logic less;
        logic overflow;
    } alu_flags_t;

    // Mul/div sequencer
    typedef enum logic [1:0] {
        MD_IDLE = 2'd0,
        MD_RUN  = 2'd1,
        MD_DONE = 2'd2
    } md_state_e;

endpackage

`default_nettype wire

//--- exec_regs.sv
`timescale 1ns/1ps
`default_nettype none

module exec_regs (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire apb_pkg::apb_req_t    req,
    output apb_pkg::apb_rsp_t         rsp,
    output exec_pkg::word_t           a,
    output exec_pkg::word_t           b,
    output exec_pkg::exec_op_e        op,
    input  wire exec_pkg::word_t      alu_result,
    input  wire exec_pkg::alu_flags_t flags,
    output logic                      md_start,
    output logic                      md_is_div,
    input  wire logic                 md_done,
    input  wire exec_pkg::word_t      hi,
    input  wire exec_pkg::word_t      lo
);
    import exec_pkg::*;
    import apb_pkg::*;

    word_t      result;
    alu_flags_t status;
    logic       md_busy;
    logic       access;
    logic       op_valid;
    logic       cmd_hit;
    logic       md_cmd;
    logic       wr_ok;
    logic       rd_ok;
    logic       slverr;
    logic       xfer_ok;

    ////////////////////////////////////////////////////////////
    // Transfer decode
    ////////////////////////////////////////////////////////////

    assign access   = req.psel && req.penable;
    // The ALU sees the command word while the write is on the bus
    assign op       = exec_op_e'(req.pwdata[3:0]);
    assign op_valid = (req.pwdata <= word_t'(OP_DIVU));
    assign cmd_hit  = (req.paddr == REG_CMD) && op_valid;
    assign md_cmd   = req.pwrite && cmd_hit && ((op == OP_MULU) || (op == OP_DIVU));
    assign wr_ok    = (req.paddr == REG_OP_A) || (req.paddr == REG_OP_B) || cmd_hit;
    assign slverr   = req.pwrite ? !wr_ok : !rd_ok;

    // Single pulse in the first access cycle of a mul/div command
    assign md_start  = access && md_cmd && !md_busy;
    assign md_is_div = (op == OP_DIVU);

    always_comb begin
        rd_ok = 1'b1;
        case (req.paddr)
            REG_OP_A:   rsp.prdata = a;
            REG_OP_B:   rsp.prdata = b;
            REG_RESULT: rsp.prdata = result;
            REG_HI:     rsp.prdata = hi;
            REG_LO:     rsp.prdata = lo;
            REG_STATUS: rsp.prdata = word_t'(status);
            default: begin
                rsp.prdata = '0;
                rd_ok      = 1'b0;
            end
        endcase
        // Wait states only while the mul/div unit runs
        rsp.pready  = access && !(md_cmd && !md_done);
        rsp.pslverr = access && slverr;
    end

    assign xfer_ok = rsp.pready && !slverr;

    ////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            a       <= '0;
            b       <= '0;
            result  <= '0;
            status  <= '0;
            md_busy <= 1'b0;
        end else begin
            if (md_start) begin
                md_busy <= 1'b1;
            end else if (md_done) begin
                md_busy <= 1'b0;
            end
            if (xfer_ok && req.pwrite) begin
                case (req.paddr)
                    REG_OP_A: a <= req.pwdata;
                    REG_OP_B: b <= req.pwdata;
                    REG_CMD: begin
                        if (md_cmd) begin
                            result <= lo;
                        end else begin
                            result <= alu_result;
                            status <= flags;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        access && !rsp.pready |=> $stable(req))
        else $error("APB request changed during a wait state");

endmodule

`default_nettype wire

//--- exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_top (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire apb_pkg::apb_req_t apb_req,
    output apb_pkg::apb_rsp_t      apb_rsp
);
    import exec_pkg::*;

    word_t      a;
    word_t      b;
    exec_op_e   op;
    word_t      alu_result;
    alu_flags_t flags;
    word_t      hi;
    word_t      lo;
    logic       md_start;
    logic       md_is_div;
    logic       md_load;
    logic       md_step;
    logic       md_done;
    logic       cnt_clear;
    logic       cnt_enable;
    logic       last_step;

    exec_regs regs_i (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .req        ( apb_req    ),
        .rsp        ( apb_rsp    ),
        .a          ( a          ),
        .b          ( b          ),
        .op         ( op         ),
        .alu_result ( alu_result ),
        .flags      ( flags      ),
        .md_start   ( md_start   ),
        .md_is_div  ( md_is_div  ),
        .md_done    ( md_done    ),
        .hi         ( hi         ),
        .lo         ( lo         )
    );

    alu_shifter alu_i (
        .a      ( a          ),
        .b      ( b          ),
        .op     ( op         ),
        .result ( alu_result ),
        .flags  ( flags      )
    );

    // Mul/div control
    md_sequencer seq_i (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .md_start   ( md_start   ),
        .last_step  ( last_step  ),
        .md_load    ( md_load    ),
        .md_step    ( md_step    ),
        .cnt_clear  ( cnt_clear  ),
        .cnt_enable ( cnt_enable ),
        .md_done    ( md_done    )
    );

    md_step_counter cnt_i (
        .clk       ( clk        ),
        .rst       ( rst        ),
        .clear     ( cnt_clear  ),
        .enable    ( cnt_enable ),
        .last_step ( last_step  )
    );

    muldiv_datapath md_i (
        .clk    ( clk       ),
        .rst    ( rst       ),
        .a      ( a         ),
        .b      ( b         ),
        .is_div ( md_is_div ),
        .load   ( md_load   ),
        .step   ( md_step   ),
        .hi     ( hi        ),
        .lo     ( lo        )
    );

endmodule

`default_nettype wire

//--- md_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module md_sequencer (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic md_start,
    input  wire logic last_step,
    output logic      md_load,
    output logic      md_step,
    output logic      cnt_clear,
    output logic      cnt_enable,
    output logic      md_done
);
    import exec_pkg::*;

    md_state_e state;
    md_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            MD_IDLE: if (md_start) state_next = MD_RUN;
            MD_RUN:  if (last_step) state_next = MD_DONE;
            MD_DONE: state_next = MD_IDLE;
            default: state_next = MD_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MD_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Operands load on the start cycle, steps follow back to back
    assign md_load    = (state == MD_IDLE) && md_start;
    assign cnt_clear  = md_load;
    assign md_step    = (state == MD_RUN);
    assign cnt_enable = md_step;
    assign md_done    = (state == MD_DONE);

    // The register block must hold off a new command while busy
    a_start_in_idle: assert property (@(posedge clk) disable iff (rst)
        md_start |-> state == MD_IDLE)
        else $error("md_start outside MD_IDLE");

    // Done comes right after the last of the counted steps and lasts one cycle
    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        md_load |-> ##(MD_STEPS + 1) md_done ##1 !md_done)
        else $error("md_done not a single pulse after the last step");

endmodule

`default_nettype wire

//--- md_step_counter.sv
`timescale 1ns/1ps
`default_nettype none

module md_step_counter (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic clear,
    input  wire logic enable,
    output logic      last_step
);
    import exec_pkg::*;

    md_count_t count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (enable) begin
            count <= count + 1'b1;
        end
    end

    // Terminal step of the iteration
    assign last_step = (count == md_count_t'(MD_STEPS - 1));

    // Counting stops at the terminal step, so the count never wraps under enable
    a_no_wrap: assert property (@(posedge clk) disable iff (rst)
        enable && last_step |=> !enable)
        else $error("step counter enabled past the terminal step");

endmodule

`default_nettype wire

//--- muldiv_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_datapath (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire exec_pkg::word_t a,
    input  wire exec_pkg::word_t b,
    input  wire logic            is_div,
    input  wire logic            load,
    input  wire logic            step,
    output exec_pkg::word_t      hi,
    output exec_pkg::word_t      lo
);
    import exec_pkg::*;

    // Multiplicand or divisor, held for the whole operation
    word_t       operand;
    logic        div_mode;

    logic [32:0] add_sum;
    logic [32:0] rem_shift;
    logic [32:0] rem_diff;
    logic        rem_ge;

    ////////////////////////////////////////////////////////////
    // Multiply, shift-add on the lo bit
    ////////////////////////////////////////////////////////////

    // Carry out of the partial product lands in hi[31] after the shift
    assign add_sum = {1'b0, hi} + {1'b0, operand};

    ////////////////////////////////////////////////////////////
    // Divide, restoring
    ////////////////////////////////////////////////////////////

    // Partial remainder with the next dividend bit shifted in
    assign rem_shift = {hi, lo[31]};
    assign rem_diff  = rem_shift - {1'b0, operand};
    assign rem_ge    = (rem_shift >= {1'b0, operand});

    // Divisor 0 always subtracts, so lo fills with ones and hi collects a

    always_ff @(posedge clk) begin
        if (rst) begin
            hi       <= '0;
            lo       <= '0;
            operand  <= '0;
            div_mode <= 1'b0;
        end else if (load) begin
            hi       <= '0;
            lo       <= a;
            operand  <= b;
            div_mode <= is_div;
        end else if (step) begin
            if (div_mode) begin
                // Quotient bit enters lo from the right
                if (rem_ge) begin
                    hi <= rem_diff[31:0];
                end else begin
                    hi <= rem_shift[31:0];
                end
                lo <= {lo[30:0], rem_ge};
            end else if (lo[0]) begin
                hi <= add_sum[32:1];
                lo <= {add_sum[0], lo[31:1]};
            end else begin
                hi <= {1'b0, hi[31:1]};
                lo <= {hi[0], lo[31:1]};
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_top;
    import exec_pkg::*;
    import apb_pkg::*;

    localparam int WAIT_LIMIT = 40;
    localparam int ALU_PAIRS  = 200;
    localparam int SHIFT_RUNS = 60;
    localparam int MD_RUNS    = 40;

    logic     clk;
    logic     rst;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     expect_err;
    int       error_count;
    int       test_count;
    int       errors_at_start;

    exec_top dut_i (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .apb_req ( apb_req ),
        .apb_rsp ( apb_rsp )
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Bus checks
    ////////////////////////////////////////////////////////////

    a_ready_in_access: assert property (@(posedge clk) disable iff (rst)
        !(apb_req.psel && apb_req.penable) |-> !apb_rsp.pready)
        else begin
            error_count++;
            $display("Error at %0t ns: pready high outside an access cycle", $time);
        end

    // Completing cycle carries the error the transfer should get
    a_slverr_match: assert property (@(posedge clk) disable iff (rst)
        apb_rsp.pready |-> apb_rsp.pslverr == expect_err)
        else begin
            error_count++;
            $display("Error at %0t ns: pslverr is %0b, expected %0b",
                     $time, apb_rsp.pslverr, expect_err);
        end

    a_slverr_on_ready: assert property (@(posedge clk) disable iff (rst)
        !apb_rsp.pready |-> !apb_rsp.pslverr)
        else begin
            error_count++;
            $display("Error at %0t ns: pslverr high during a wait state", $time);
        end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic word_t model_result(input exec_op_e op, input word_t a, input word_t b);
        logic [63:0] sign_ext;
        logic [63:0] shifted;
        sign_ext = {{32{b[31]}}, b};
        shifted  = sign_ext >> a[4:0];
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_NOR:  return ~(a | b);
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            OP_SLL:  return b << a[4:0];
            OP_SRL:  return b >> a[4:0];
            OP_SRA:  return shifted[31:0];
            default: return '0;
        endcase
    endfunction

    function automatic alu_flags_t model_flags(input exec_op_e op, input word_t a, input word_t b);
        alu_flags_t  f;
        logic [63:0] wide;
        logic        is_shift;
        is_shift = (op == OP_SLL) || (op == OP_SRL) || (op == OP_SRA);
        wide     = '0;
        if (op == OP_ADD) begin
            wide = {{32{a[31]}}, a} + {{32{b[31]}}, b};
        end else if (op == OP_SUB) begin
            wide = {{32{a[31]}}, a} - {{32{b[31]}}, b};
        end
        f.zero     = (model_result(op, a, b) == '0);
        f.less     = !is_shift && ($signed(a) < $signed(b));
        // Result fits in 32 signed bits only if bits 63 to 31 agree
        f.overflow = (wide[63:31] != '0) && (wide[63:31] != '1);
        return f;
    endfunction

    function automatic word_t corner_value(input int idx);
        case (idx)
            0:       return 32'h7fff_ffff;
            1:       return 32'h8000_0000;
            2:       return 32'hffff_ffff;
            3:       return 32'h0000_0001;
            default: return 32'h0000_0000;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Bus tasks
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string what, input word_t got, input word_t exp);
        assert (got === exp)
            else begin
                error_count++;
                $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h",
                         $time, what, got, exp);
            end
    endtask

    task automatic bus_idle();
        apb_req    = '0;
        expect_err = 1'b0;
    endtask

    // Stays in the access phase until pready, counting wait states
    task automatic wait_ready(output int waits);
        waits = 0;
        while (!apb_rsp.pready && waits < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            waits++;
        end
        if (!apb_rsp.pready) begin
            $display("Timeout: no pready after %0d wait states at %0t ns", WAIT_LIMIT, $time);
            $display("Test failed");
            $finish;
        end
    endtask

    task automatic apb_write(input apb_addr_t addr, input word_t data, input logic err,
                             output int waits);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        expect_err      = err;
        @(posedge clk);
        #2;
        apb_req.penable = 1'b1;
        wait_ready(waits);
        @(posedge clk);
        #2;
        bus_idle();
    endtask

    task automatic apb_read(input apb_addr_t addr, input logic err, output word_t data);
        int waits;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        apb_req.pwdata  = '0;
        expect_err      = err;
        @(posedge clk);
        #2;
        apb_req.penable = 1'b1;
        wait_ready(waits);
        data = apb_rsp.prdata;
        @(posedge clk);
        #2;
        bus_idle();
    endtask

    task automatic write_reg(input apb_addr_t addr, input word_t data);
        int waits;
        apb_write(addr, data, 1'b0, waits);
    endtask

    task automatic check_read(input apb_addr_t addr, input word_t exp, input string what);
        word_t data;
        apb_read(addr, 1'b0, data);
        check_value(what, data, exp);
    endtask

    ////////////////////////////////////////////////////////////
    // Operations
    ////////////////////////////////////////////////////////////

    task automatic run_alu(input exec_op_e op, input word_t a, input word_t b);
        write_reg(REG_OP_A, a);
        write_reg(REG_OP_B, b);
        write_reg(REG_CMD, word_t'(op));
        check_read(REG_RESULT, model_result(op, a, b), $sformatf("%s result", op.name()));
        check_read(REG_STATUS, word_t'(model_flags(op, a, b)),
                   $sformatf("%s status", op.name()));
    endtask

    task automatic run_md(input exec_op_e op, input word_t a, input word_t b);
        logic [63:0] prod;
        word_t       exp_hi;
        word_t       exp_lo;
        int          waits;
        write_reg(REG_OP_A, a);
        write_reg(REG_OP_B, b);
        apb_write(REG_CMD, word_t'(op), 1'b0, waits);
        assert (waits >= 1)
            else begin
                error_count++;
                $display("Error at %0t ns: %s completed without a wait state",
                         $time, op.name());
            end
        prod = {32'd0, a} * {32'd0, b};
        if (op == OP_MULU) begin
            exp_hi = prod[63:32];
            exp_lo = prod[31:0];
        end else if (b == '0) begin
            exp_hi = a;
            exp_lo = '1;
        end else begin
            exp_hi = a % b;
            exp_lo = a / b;
        end
        check_read(REG_HI, exp_hi, $sformatf("%s hi", op.name()));
        check_read(REG_LO, exp_lo, $sformatf("%s lo", op.name()));
        check_read(REG_RESULT, exp_lo, $sformatf("%s result", op.name()));
    endtask

    task automatic finish_test(input string name);
        test_count++;
        $display("%s: done, %0d errors", name, error_count - errors_at_start);
        errors_at_start = error_count;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        word_t    a;
        word_t    b;
        word_t    op_a_before;
        word_t    result_before;
        word_t    data;
        exec_op_e op;
        int       sel;
        int       waits;
        void'($urandom(24));
        clk             = 1'b0;
        rst             = 1'b1;
        apb_req         = '0;
        expect_err      = 1'b0;
        error_count     = 0;
        test_count      = 0;
        errors_at_start = 0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        check_value("pready at idle", word_t'(apb_rsp.pready), '0);
        check_read(REG_RESULT, '0, "result after reset");
        check_read(REG_HI, '0, "hi after reset");
        check_read(REG_LO, '0, "lo after reset");
        check_read(REG_STATUS, '0, "status after reset");
        finish_test("reset_values");

        // Signed limits first, then a mix of corners and random words
        run_alu(OP_ADD, 32'h7fff_ffff, 32'h0000_0001);
        run_alu(OP_SUB, 32'h8000_0000, 32'h0000_0001);
        for (int i = 0; i < ALU_PAIRS; i++) begin
            op = exec_op_e'(4'($urandom_range(7, 0)));
            if (i % 4 == 0) begin
                a = corner_value(int'($urandom_range(4, 0)));
                b = corner_value(int'($urandom_range(4, 0)));
            end else begin
                a = $urandom();
                b = $urandom();
            end
            run_alu(op, a, b);
        end
        finish_test("alu_random");

        for (int i = 0; i < SHIFT_RUNS; i++) begin
            sel = int'($urandom_range(2, 0));
            op  = (sel == 0) ? OP_SLL : ((sel == 1) ? OP_SRL : OP_SRA);
            run_alu(op, $urandom(), $urandom());
        end
        finish_test("shift_random");

        run_md(OP_DIVU, $urandom(), '0);
        for (int i = 0; i < MD_RUNS; i++) begin
            op = ($urandom_range(1, 0) == 0) ? OP_MULU : OP_DIVU;
            a  = $urandom();
            b  = (i % 3 == 0) ? word_t'($urandom_range(255, 0)) : $urandom();
            if (i % 8 == 0) begin
                b = '0;
            end
            run_md(op, a, b);
        end
        finish_test("muldiv_random");

        // Rejected transfers must leave the registers alone
        apb_read(REG_OP_A, 1'b0, op_a_before);
        apb_read(REG_RESULT, 1'b0, result_before);
        apb_write(REG_RESULT, 32'hdead_beef, 1'b1, waits);
        apb_read(REG_CMD, 1'b1, data);
        apb_write(8'h40, 32'h1234_5678, 1'b1, waits);
        apb_read(8'h40, 1'b1, data);
        apb_write(REG_CMD, 32'd13, 1'b1, waits);
        check_read(REG_OP_A, op_a_before, "operand A after bus errors");
        check_read(REG_RESULT, result_before, "result after bus errors");
        finish_test("bus_errors");

        $display("Tests run: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
